//--- filelist.f
rv_pkg.sv
rv_alu.sv
rv_decode.sv
rv_regfile.sv
rv_mem_wb.sv
rv_fetch.sv
rv_core.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  logic            src_imm,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::alu_op_e alu_op,
    input  rv_pkg::word_t   cmp_a,
    input  rv_pkg::word_t   cmp_b,
    input  rv_pkg::br_op_e  br_op,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);
    import rv_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign op_b  = src_imm ? imm : b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_sub:  result = a - op_b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, $signed(a) < $signed(op_b)};
            alu_sltu: result = {31'b0, a < op_b};
            alu_xor:  result = a ^ op_b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | op_b;
            alu_and:  result = a & op_b;
            default:  result = a + op_b;
        endcase
    end

    // branch compare always uses the two register values
    assign eq   = (cmp_a == cmp_b);
    assign lt_s = $signed(cmp_a) < $signed(cmp_b);
    assign lt_u = cmp_a < cmp_b;

    always_comb begin
        case (br_op)
            br_bne:  branch_taken = !eq;
            br_blt:  branch_taken = lt_s;
            br_bge:  branch_taken = !lt_s;
            br_bltu: branch_taken = lt_u;
            br_bgeu: branch_taken = !lt_u;
            default: branch_taken = eq;
        endcase
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic             inst_selfdefine,
    input  logic             reset,
    output logic             imem_req,
    output rv_pkg::word_t    imem_addr,
    input  logic             imem_ack,
    input  rv_pkg::inst_t    imem_rdata,
    output logic             dmem_req,
    output logic             dmem_we,
    output rv_pkg::word_t    dmem_addr,
    output rv_pkg::byte_en_t dmem_be,
    output rv_pkg::word_t    dmem_wdata,
    input  logic             dmem_ack,
    input  rv_pkg::word_t    dmem_rdata
);
    import rv_pkg::*;

    inst_t     inst;
    word_t     link_pc;
    word_t     imm;
    word_t     alu_result;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_data;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    reg_idx_t  rd_idx;
    alu_op_e   alu_op;
    br_op_e    br_op;
    wb_sel_e   wb_sel;
    mem_kind_e mem_kind;
    logic      rd_we;
    logic      src_imm;
    logic      is_jump;
    logic      is_jalr;
    logic      is_branch;
    logic      branch_taken;
    logic      mem_start;
    logic      mem_done;
    logic      retire;

    rv_fetch u_fetch (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_rdata(imem_rdata),
        .inst(inst), .pc(), .link_pc(link_pc),
        .is_jump(is_jump), .is_jalr(is_jalr),
        .is_branch(is_branch), .branch_taken(branch_taken),
        .imm(imm), .alu_result(alu_result), .mem_kind(mem_kind),
        .mem_start(mem_start), .mem_done(mem_done), .retire(retire)
    );

    rv_decode u_decode (
        .inst(inst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx), .rd_we(rd_we),
        .imm(imm), .alu_op(alu_op), .br_op(br_op), .src_imm(src_imm),
        .is_jump(is_jump), .is_jalr(is_jalr), .is_branch(is_branch),
        .mem_kind(mem_kind), .wb_sel(wb_sel)
    );

    rv_alu u_alu (
        .a(rs1_data), .b(rs2_data), .src_imm(src_imm), .imm(imm), .alu_op(alu_op),
        .cmp_a(rs1_data), .cmp_b(rs2_data), .br_op(br_op),
        .result(alu_result), .branch_taken(branch_taken)
    );

    // write happens only in the retire cycle
    rv_regfile u_regfile (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx),
        .we(retire), .wr_ok(rd_we), .wdata(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_mem_wb u_mem_wb (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .mem_kind(mem_kind), .wb_sel(wb_sel),
        .addr(alu_result), .store_data(rs2_data),
        .alu_result(alu_result), .link_pc(link_pc), .imm(imm),
        .mem_start(mem_start), .mem_done(mem_done),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_be(dmem_be), .dmem_wdata(dmem_wdata),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
        .rd_data(rd_data)
    );

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  rv_pkg::inst_t     inst,
    output rv_pkg::reg_idx_t  rs1_idx,
    output rv_pkg::reg_idx_t  rs2_idx,
    output rv_pkg::reg_idx_t  rd_idx,
    output logic              rd_we,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_e   alu_op,
    output rv_pkg::br_op_e    br_op,
    output logic              src_imm,
    output logic              is_jump,
    output logic              is_jalr,
    output logic              is_branch,
    output rv_pkg::mem_kind_e mem_kind,
    output rv_pkg::wb_sel_e   wb_sel
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       wr_en;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_shamt;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign rd_idx  = inst[11:7];
    assign rd_we   = wr_en && (rd_idx != 5'd0);

    assign imm_i     = {{20{inst[31]}}, inst[31:20]};
    assign imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u     = {inst[31:12], 12'b0};
    assign imm_j     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_shamt = {27'b0, inst[24:20]};

    always_comb begin
        wr_en     = 1'b0;
        imm       = '0;
        alu_op    = alu_add;
        br_op     = br_beq;
        src_imm   = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        is_branch = 1'b0;
        mem_kind  = mem_none;
        wb_sel    = wb_alu;
        case (opcode)
            op_lui: begin
                wr_en  = 1'b1;
                imm    = imm_u;
                wb_sel = wb_imm;
            end
            op_jal: begin
                wr_en   = 1'b1;
                imm     = imm_j;
                is_jump = 1'b1;
                wb_sel  = wb_link;
            end
            // target comes from rs1 + imm through the alu
            op_jalr: begin
                wr_en   = 1'b1;
                imm     = imm_i;
                src_imm = 1'b1;
                is_jump = 1'b1;
                is_jalr = 1'b1;
                wb_sel  = wb_link;
            end
            op_branch: begin
                imm       = imm_b;
                is_branch = 1'b1;
                case (funct3)
                    3'b000:  br_op = br_beq;
                    3'b001:  br_op = br_bne;
                    3'b100:  br_op = br_blt;
                    3'b101:  br_op = br_bge;
                    3'b110:  br_op = br_bltu;
                    3'b111:  br_op = br_bgeu;
                    default: is_branch = 1'b0;
                endcase
            end
            op_load: begin
                imm     = imm_i;
                src_imm = 1'b1;
                wb_sel  = wb_load;
                case (funct3)
                    3'b000:  mem_kind = mem_lb;
                    3'b010:  mem_kind = mem_lw;
                    3'b100:  mem_kind = mem_lbu;
                    default: mem_kind = mem_none;
                endcase
                wr_en = (mem_kind != mem_none);
            end
            op_store: begin
                imm     = imm_s;
                src_imm = 1'b1;
                case (funct3)
                    3'b000:  mem_kind = mem_sb;
                    3'b010:  mem_kind = mem_sw;
                    default: mem_kind = mem_none;
                endcase
            end
            op_imm: begin
                wr_en   = 1'b1;
                imm     = imm_i;
                src_imm = 1'b1;
                case (funct3)
                    3'b000: alu_op = alu_add;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    3'b001: begin
                        alu_op = alu_sll;
                        imm    = imm_shamt;
                    end
                    default: begin
                        alu_op = inst[30] ? alu_sra : alu_srl;
                        imm    = imm_shamt;
                    end
                endcase
            end
            op_reg: begin
                wr_en = 1'b1;
                case (funct3)
                    3'b000:  alu_op = inst[30] ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            // anything else retires without side effects
            default: wr_en = 1'b0;
        endcase
    end

endmodule

//--- rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic              inst_selfdefine,
    input  logic              reset,
    output logic              imem_req,
    output rv_pkg::word_t     imem_addr,
    input  logic              imem_ack,
    input  rv_pkg::inst_t     imem_rdata,
    output rv_pkg::inst_t     inst,
    output rv_pkg::word_t     pc,
    output rv_pkg::word_t     link_pc,
    input  logic              is_jump,
    input  logic              is_jalr,
    input  logic              is_branch,
    input  logic              branch_taken,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::word_t     alu_result,
    input  rv_pkg::mem_kind_e mem_kind,
    output logic              mem_start,
    input  logic              mem_done,
    output logic              retire
);
    import rv_pkg::*;

    seq_state_e state;
    word_t      next_pc;

    assign imem_addr = pc;
    assign link_pc   = pc + 32'd4;
    assign mem_start = (state == st_execute) && (mem_kind != mem_none);
    assign retire    = (state == st_retire);

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (is_jump || (is_branch && branch_taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = link_pc;
        end
    end

    // instruction word is held until the next fetch completes
    always_ff @(posedge inst_selfdefine) begin
        if (state == st_fetch_req && imem_req && imem_ack) begin
            inst <= imem_rdata;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state    <= st_fetch_req;
            pc       <= pc_reset;
            imem_req <= 1'b0;
        end else begin
            case (state)
                st_fetch_req: begin
                    if (!imem_req) begin
                        imem_req <= 1'b1;
                    end else if (imem_ack) begin
                        imem_req <= 1'b0;
                        state    <= st_fetch_release;
                    end
                end
                // wait for the memory to drop ack
                st_fetch_release: begin
                    if (!imem_ack) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    state <= (mem_kind != mem_none) ? st_mem_wait : st_retire;
                end
                st_mem_wait: begin
                    if (mem_done) begin
                        state <= st_retire;
                    end
                end
                st_retire: begin
                    pc    <= next_pc;
                    state <= st_fetch_req;
                end
                default: state <= st_fetch_req;
            endcase
        end
    end

endmodule

//--- rv_mem_wb.sv
`timescale 1ns/1ps

module rv_mem_wb (
    input  logic              inst_selfdefine,
    input  logic              reset,
    input  rv_pkg::mem_kind_e mem_kind,
    input  rv_pkg::wb_sel_e   wb_sel,
    input  rv_pkg::word_t     addr,
    input  rv_pkg::word_t     store_data,
    input  rv_pkg::word_t     alu_result,
    input  rv_pkg::word_t     link_pc,
    input  rv_pkg::word_t     imm,
    input  logic              mem_start,
    output logic              mem_done,
    output logic              dmem_req,
    output logic              dmem_we,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::byte_en_t  dmem_be,
    output rv_pkg::word_t     dmem_wdata,
    input  logic              dmem_ack,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     rd_data
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        mw_idle,
        mw_wait_ack,
        mw_wait_release
    } mw_state_e;

    mw_state_e  mstate;
    word_t      load_word;
    word_t      load_data;
    logic [7:0] load_byte;

    assign dmem_addr  = addr;
    assign dmem_we    = (mem_kind == mem_sw) || (mem_kind == mem_sb);
    assign dmem_be    = (mem_kind == mem_sb) ? byte_en_t'(4'b0001 << addr[1:0]) : 4'b1111;
    assign dmem_wdata = (mem_kind == mem_sb) ? {4{store_data[7:0]}} : store_data;
    assign mem_done   = (mstate == mw_wait_release) && !dmem_ack;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mstate   <= mw_idle;
            dmem_req <= 1'b0;
        end else begin
            case (mstate)
                mw_idle: begin
                    if (mem_start) begin
                        dmem_req <= 1'b1;
                        mstate   <= mw_wait_ack;
                    end
                end
                mw_wait_ack: begin
                    if (dmem_ack) begin
                        dmem_req <= 1'b0;
                        mstate   <= mw_wait_release;
                    end
                end
                default: begin
                    if (!dmem_ack) begin
                        mstate <= mw_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (mstate == mw_wait_ack && dmem_ack) begin
            load_word <= dmem_rdata;
        end
    end

    // byte lane picked by the low address bits
    assign load_byte = load_word[8*addr[1:0] +: 8];

    always_comb begin
        case (mem_kind)
            mem_lb:  load_data = {{24{load_byte[7]}}, load_byte};
            mem_lbu: load_data = {24'b0, load_byte};
            default: load_data = load_word;
        endcase
    end

    always_comb begin
        case (wb_sel)
            wb_load: rd_data = load_data;
            wb_link: rd_data = link_pc;
            wb_imm:  rd_data = imm;
            default: rd_data = alu_result;
        endcase
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      byte_en_t;

    localparam word_t pc_reset = 32'h0000_0000;

    // major opcodes of the kept subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } br_op_e;

    // source of the value written back to rd
    typedef enum logic [1:0] {
        wb_alu, wb_load, wb_link, wb_imm
    } wb_sel_e;

    typedef enum logic [2:0] {
        mem_none, mem_lw, mem_lb, mem_lbu, mem_sw, mem_sb
    } mem_kind_e;

    typedef enum logic [2:0] {
        st_fetch_req,
        st_fetch_release,
        st_execute,
        st_mem_wait,
        st_retire
    } seq_state_e;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             inst_selfdefine,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::reg_idx_t rd_idx,
    input  logic             we,
    input  logic             wr_ok,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_ok && rd_idx != 5'd0) begin
            regs[rd_idx] <= wdata;
        end
    end

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t data_base = 32'h0000_0100;
    localparam word_t sentinel  = 32'hffff_fffc;
    localparam int    wait_max  = 20000;

    logic     inst_selfdefine;
    logic     reset;
    logic     imem_req;
    word_t    imem_addr;
    logic     imem_ack;
    inst_t    imem_rdata;
    logic     dmem_req;
    logic     dmem_we;
    word_t    dmem_addr;
    byte_en_t dmem_be;
    word_t    dmem_wdata;
    logic     dmem_ack;
    word_t    dmem_rdata;

    inst_t    imem [0:255];
    word_t    dmem [0:1023];
    int       wp;
    int       off;
    int       marker;
    int       errors;
    int       nchecks;
    logic     done;
    logic     rand_on;
    logic [31:0] seed;
    int       icnt;
    int       dcnt;

    word_t    exp_addr [$];
    byte_en_t exp_be [$];
    word_t    exp_data [$];
    word_t    cap_addr [$];
    byte_en_t cap_be [$];
    word_t    cap_data [$];
    word_t    ref_data [$];

    rv_core dut0 (
        .inst_selfdefine(inst_selfdefine), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_be(dmem_be), .dmem_wdata(dmem_wdata),
        .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata)
    );

    always #50 inst_selfdefine = ~inst_selfdefine;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction encoders
    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // RV32I branch conditions by funct3
    function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // four-phase instruction memory
    always @(negedge inst_selfdefine) begin
        if (reset) begin
            imem_ack = 1'b0;
        end else if (imem_req && !imem_ack) begin
            if (icnt == 0) begin
                imem_rdata = imem[imem_addr[9:2]];
                imem_ack   = 1'b1;
                seed       = xorshift(seed);
                icnt       = rand_on ? int'(seed[1:0]) : 0;
            end else begin
                icnt = icnt - 1;
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack = 1'b0;
        end
    end

    // four-phase data memory that logs every store
    always @(negedge inst_selfdefine) begin
        if (reset) begin
            dmem_ack = 1'b0;
        end else if (dmem_req && !dmem_ack) begin
            if (dcnt == 0) begin
                if (!dmem_we) begin
                    dmem_rdata = dmem[dmem_addr[11:2]];
                end else if (dmem_addr == sentinel) begin
                    done = 1'b1;
                end else begin
                    cap_addr.push_back(dmem_addr);
                    cap_be.push_back(dmem_be);
                    cap_data.push_back(dmem_wdata);
                    for (int k = 0; k < 4; k++) begin
                        if (dmem_be[k]) begin
                            dmem[dmem_addr[11:2]][8*k +: 8] = dmem_wdata[8*k +: 8];
                        end
                    end
                end
                dmem_ack = 1'b1;
                seed     = xorshift(seed);
                dcnt     = rand_on ? int'(seed[1:0]) : 0;
            end else begin
                dcnt = dcnt - 1;
            end
        end else if (!dmem_req && dmem_ack) begin
            dmem_ack = 1'b0;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        nchecks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
        nchecks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        nchecks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic emit(input inst_t i);
        imem[wp] = i;
        wp++;
    endtask

    task automatic expect_store(input word_t a, input byte_en_t be, input word_t d);
        exp_addr.push_back(a);
        exp_be.push_back(be);
        exp_data.push_back(d);
    endtask

    // sw rs to the next result slot
    task automatic store_x(input reg_idx_t rs, input word_t d);
        emit(enc_s(off[11:0], rs, 5'd10, 3'b010));
        expect_store(data_base + word_t'(off), 4'b1111, d);
        off += 4;
    endtask

    task automatic begin_program();
        // every unused word decodes as addi x0, x0, index
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, op_imm);
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 32'h5a00_0000 ^ word_t'(i * 32'h0001_0003);
        end
        exp_addr.delete();
        exp_be.delete();
        exp_data.delete();
        cap_addr.delete();
        cap_be.delete();
        cap_data.delete();
        wp  = 0;
        off = 0;
        emit(enc_i(12'h100, 5'd0, 3'b000, 5'd10, op_imm));
    endtask

    // reset, reset-state checks, then run until the sentinel store
    task automatic run_program(input string name);
        int n;
        emit(enc_s(12'hffc, 5'd0, 5'd0, 3'b010));
        emit(enc_j(21'd0, 5'd0));
        @(negedge inst_selfdefine);
        reset = 1'b1;
        done  = 1'b0;
        repeat (10) @(negedge inst_selfdefine);
        check_bit({name, " imem_req in reset"}, 1'b0, imem_req);
        check_bit({name, " dmem_req in reset"}, 1'b0, dmem_req);
        reset = 1'b0;
        n = 0;
        while (!imem_req && n < wait_max) begin
            @(negedge inst_selfdefine);
            n++;
        end
        if (!imem_req) begin
            errors++;
            $display("%s: the core never raised imem_req after reset", name);
        end
        check_word({name, " first imem_addr"}, pc_reset, imem_addr);
        n = 0;
        while (!done && n < wait_max) begin
            @(negedge inst_selfdefine);
            n++;
        end
        if (!done) begin
            errors++;
            $display("%s: the core never reached the sentinel", name);
        end
    endtask

    task automatic check_writes(input string name);
        int n;
        check_word({name, " store count"}, word_t'(exp_addr.size()), word_t'(cap_addr.size()));
        n = (exp_addr.size() < cap_addr.size()) ? exp_addr.size() : cap_addr.size();
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("%s addr %0d", name, i), exp_addr[i], cap_addr[i]);
            check_be($sformatf("%s be %0d", name, i), exp_be[i], cap_be[i]);
            check_word($sformatf("%s data %0d", name, i), exp_data[i], cap_data[i]);
        end
    endtask

    task automatic alu_case(input inst_t i, input word_t d);
        emit(i);
        store_x(5'd4, d);
    endtask

    task automatic test_arith(input string name);
        word_t a;
        word_t b;
        a = 32'h1234_5678;
        b = 32'hffff_fff9;
        begin_program();
        emit({20'h12345, 5'd1, op_lui});
        emit(enc_i(12'h678, 5'd1, 3'b000, 5'd1, op_imm));
        emit(enc_i(12'hff9, 5'd0, 3'b000, 5'd2, op_imm));
        emit(enc_i(12'h005, 5'd0, 3'b000, 5'd3, op_imm));
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), a + b);
        alu_case(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), a - b);
        alu_case(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd4), a << 5);
        alu_case(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd4), ($signed(b) < $signed(a)) ? 1 : 0);
        alu_case(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd4), (b < a) ? 1 : 0);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd4), a ^ b);
        alu_case(enc_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd4), a >> 5);
        alu_case(enc_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd4), word_t'($signed(b) >>> 5));
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd4), a | b);
        alu_case(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd4), a & b);
        alu_case(enc_i(12'hf9c, 5'd1, 3'b000, 5'd4, op_imm), a + 32'hffff_ff9c);
        alu_case(enc_i(12'hffd, 5'd2, 3'b010, 5'd4, op_imm), ($signed(b) < -3) ? 1 : 0);
        alu_case(enc_i(12'h005, 5'd2, 3'b011, 5'd4, op_imm), (b < 32'd5) ? 1 : 0);
        alu_case(enc_i(12'h7ff, 5'd1, 3'b100, 5'd4, op_imm), a ^ 32'h0000_07ff);
        alu_case(enc_i(12'hf00, 5'd1, 3'b110, 5'd4, op_imm), a | 32'hffff_ff00);
        alu_case(enc_i(12'h0f0, 5'd1, 3'b111, 5'd4, op_imm), a & 32'h0000_00f0);
        alu_case(enc_i(12'h004, 5'd1, 3'b001, 5'd4, op_imm), a << 4);
        alu_case(enc_i(12'h008, 5'd2, 3'b101, 5'd4, op_imm), b >> 8);
        alu_case(enc_i(12'h402, 5'd2, 3'b101, 5'd4, op_imm), word_t'($signed(b) >>> 2));
        run_program(name);
        check_writes(name);
    endtask

    task automatic test_load_store();
        word_t w;
        w = 32'h1234_50f6;
        begin_program();
        emit({20'h12345, 5'd1, op_lui});
        store_x(5'd1, 32'h1234_5000);
        emit(enc_i(12'h0f6, 5'd1, 3'b000, 5'd1, op_imm));
        store_x(5'd1, w);
        emit(enc_i(12'd4, 5'd10, 3'b000, 5'd5, op_load));
        store_x(5'd5, {{24{w[7]}}, w[7:0]});
        emit(enc_i(12'd4, 5'd10, 3'b100, 5'd5, op_load));
        store_x(5'd5, {24'b0, w[7:0]});
        emit(enc_i(12'd5, 5'd10, 3'b000, 5'd5, op_load));
        store_x(5'd5, {{24{w[15]}}, w[15:8]});
        emit(enc_i(12'd4, 5'd10, 3'b010, 5'd5, op_load));
        store_x(5'd5, w);
        // byte store to lane 2
        emit(enc_s(12'd26, 5'd1, 5'd10, 3'b000));
        expect_store(data_base + 32'd26, 4'b0100, {4{w[7:0]}});
        run_program("load_store");
        check_writes("load_store");
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input word_t va,
                               input reg_idx_t rs2, input word_t vb);
        emit(enc_i(marker[11:0], 5'd0, 3'b000, 5'd6, op_imm));
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(marker[11:0] + 12'd1, 5'd0, 3'b000, 5'd6, op_imm));
        store_x(5'd6, branch_rule(f3, va, vb) ? word_t'(marker) : word_t'(marker + 1));
        marker += 2;
    endtask

    task automatic test_branch();
        word_t v1;
        word_t v2;
        word_t p;
        v1 = 32'd5;
        v2 = 32'hffff_fffd;
        marker = 16;
        begin_program();
        emit(enc_i(12'h005, 5'd0, 3'b000, 5'd1, op_imm));
        emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, op_imm));
        emit(enc_i(12'h005, 5'd0, 3'b000, 5'd3, op_imm));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branch_case(f[2:0], 5'd1, v1, 5'd3, v1);
                branch_case(f[2:0], 5'd1, v1, 5'd2, v2);
                branch_case(f[2:0], 5'd2, v2, 5'd1, v1);
            end
        end
        // jal over a stray store
        p = word_t'(wp * 4);
        emit(enc_j(21'd12, 5'd7));
        emit(enc_i(12'd99, 5'd0, 3'b000, 5'd6, op_imm));
        emit(enc_s(12'd200, 5'd6, 5'd10, 3'b010));
        store_x(5'd7, p + 32'd4);
        // jalr with an odd target sum
        p = word_t'((wp + 1) * 4);
        emit(enc_i(p[11:0] + 12'd8, 5'd0, 3'b000, 5'd8, op_imm));
        emit(enc_i(12'd1, 5'd8, 3'b000, 5'd9, op_jalr));
        emit(enc_s(12'd200, 5'd6, 5'd10, 3'b010));
        store_x(5'd9, p + 32'd4);
        run_program("branch");
        check_writes("branch");
    endtask

    task automatic test_x0();
        begin_program();
        emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, op_imm));
        store_x(5'd0, 32'd0);
        emit(enc_i(12'h005, 5'd0, 3'b000, 5'd1, op_imm));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        store_x(5'd0, 32'd0);
        run_program("x0");
        check_writes("x0");
    endtask

    initial begin
        inst_selfdefine = 1'b0;
        reset      = 1'b1;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        rand_on    = 1'b0;
        seed       = 32'h853e;
        icnt       = 0;
        dcnt       = 0;
        done       = 1'b0;
        errors     = 0;
        nchecks    = 0;

        test_arith("arith");
        ref_data = cap_data;
        test_load_store();
        test_branch();
        test_x0();

        // same program under random ack delays
        rand_on = 1'b1;
        test_arith("arith_slow");
        check_word("arith_slow store count", word_t'(ref_data.size()),
                   word_t'(cap_data.size()));
        for (int i = 0; i < ref_data.size() && i < cap_data.size(); i++) begin
            check_word($sformatf("arith_slow repeat %0d", i), ref_data[i], cap_data[i]);
        end

        $display("checks: %0d, errors: %0d", nchecks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
